// ==== bench/adc_tb.sv ====
// Testbench for adc_top with ADC model, APB tasks, reference average, output monitor and watchdog
`default_nettype none

`include "adc_settings.svh"

module adc_tb
    import adc_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int TOTAL_SLOTS   = 20 * 1 + 12 * 4 + 12 * 7 + 24 * 1 + 1;  // Outputs x (N+1)
    localparam int MARGIN_CYCLES = 800;                 // APB traffic and idle checks
    localparam int TIMEOUT       = (TOTAL_SLOTS * 2 + MARGIN_CYCLES) * CLK_PERIOD;

    // DUT ports
    logic        clk_i;
    logic        arst_n;
    adc_sample_t adc_data;
    logic        adc_oe;
    logic        clk_o;
    adc_sample_t out_data;
    logic        out_rdy;
    logic        out_ack;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;

    integer      seed;
    int          err_value;         // Wrong values
    int          err_other;         // Anything else
    logic        dut_enable;        // Mirrors CTRL bit 0 with the same timing
    int          decim_n;           // DECIM value set while disabled

    // Handshake model state
    adc_sample_t kept [$];          // Kept samples of the current run
    logic        model_rdy;
    logic        take_next;         // Kept sample reaches the filter at the next edge
    logic        prev_enable;
    int          smp_idx;           // Samples taken since enable rose
    int          n_accepted;
    int          ovr_model;         // Expected overrun count
    adc_sample_t exp_data;          // Value that should sit under out_rdy
    adc_sample_t pending;           // Average including the latest kept sample
    adc_sample_t last_sampled;
    adc_sample_t first_kept;
    adc_sample_t last_accepted;

    adc_top DUT (
        .clk_i    (clk_i),
        .arst_n   (arst_n),
        .adc_data (adc_data),
        .adc_oe   (adc_oe),
        .clk_o    (clk_o),
        .out_data (out_data),
        .out_rdy  (out_rdy),
        .out_ack  (out_ack),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ADC model drives a new word at the edge that raises clk_o
    always @(posedge clk_i) begin
        if (arst_n && dut_enable && !clk_o) begin
            adc_data <= adc_sample_t'($random(seed));
        end
    end

    // Sum of the last 16 kept samples over 16 with missing ones as zero
    function automatic adc_sample_t ref_average(input adc_sample_t q [$]);
        int sum;
        int first;
        sum   = 0;
        first = (q.size() > `MA_LEN) ? q.size() - `MA_LEN : 0;
        for (int i = first; i < q.size(); i++) begin
            sum += int'(q[i]);
        end
        return adc_sample_t'(sum / `MA_LEN);
    endfunction

    task automatic check_sample(input string name, input adc_sample_t got, input adc_sample_t exp);
        if (got !== exp) begin
            err_value++;
            $display("error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input ovr_count_t got, input ovr_count_t exp);
        if (got !== exp) begin
            err_value++;
            $display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            err_value++;
            $display("error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_value++;
            $display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // Setup phase, access phase, then idle
    task automatic reg_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk_i);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk_i);
        penable <= 1'b1;
        @(posedge clk_i);                   // Write lands here
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        if (addr == `REG_CTRL_ADDR) begin
            dut_enable <= data[0];
        end
    endtask

    task automatic reg_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk_i);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk_i);
        penable <= 1'b1;
        @(posedge clk_i);
        data = prdata;                      // Combinational in the access phase
        err  = pslverr;
        check_flag("pready", pready, 1'b1); // No wait states
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_expect(input apb_addr_t addr, input string name, input apb_data_t exp);
        apb_data_t rd;
        logic      err;
        reg_read(addr, rd, err);
        check_data(name, rd, exp);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic wait_outputs(input int target);
        while (n_accepted < target) begin
            @(posedge clk_i);
        end
    endtask

    // Enabled run with decimation n until a number of outputs is accepted
    task automatic run_session(input int n, input int outputs);
        int target;
        reg_write(`REG_DECIM_ADDR, apb_data_t'(n));
        decim_n = n;
        target  = n_accepted + outputs;
        reg_write(`REG_CTRL_ADDR, 32'h3);
        wait_outputs(target);
        reg_write(`REG_CTRL_ADDR, 32'h2);   // Disable with oe left on
        repeat (4) @(posedge clk_i);
    endtask

    // Output monitor against the handshake model
    always @(posedge clk_i) begin : monitor
        logic take;
        if (!arst_n) begin
            model_rdy     = 1'b0;
            take_next     = 1'b0;
            prev_enable   = 1'b0;
            smp_idx       = 0;
            n_accepted    = 0;
            ovr_model     = 0;
            exp_data      = '0;
            pending       = '0;
            last_sampled  = '0;
            first_kept    = '0;
            last_accepted = '0;
            kept.delete();
        end else begin
            take      = take_next && dut_enable;        // smp_valid meets enable
            take_next = 1'b0;
            check_flag("out_rdy", out_rdy, model_rdy);
            if (model_rdy) begin
                check_sample("out_data", out_data, exp_data);   // Also holds while stalled
            end
            if (model_rdy && out_ack) begin
                n_accepted++;
                last_accepted = out_data;
            end
            if (take) begin
                if (!model_rdy || out_ack) begin
                    exp_data  = pending;
                    model_rdy = 1'b1;
                end else begin
                    ovr_model++;                        // Result lost but window keeps sample
                end
            end else if (model_rdy && out_ack) begin
                model_rdy = 1'b0;
            end
            // Window and decimation restart when enable rises
            if (dut_enable && !prev_enable) begin
                kept.delete();
                smp_idx = 0;
            end
            prev_enable = dut_enable;
            if (dut_enable && clk_o) begin              // Sample taken where clk_o falls
                last_sampled = adc_data;
                if (smp_idx % (decim_n + 1) == 0) begin
                    kept.push_back(adc_data);
                    if (kept.size() == 1) begin
                        first_kept = adc_data;
                    end
                    pending   = ref_average(kept);
                    take_next = 1'b1;
                end
                smp_idx++;
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("errors: %0d wrong values, %0d other, %0d outputs checked",
                 err_value, err_other + 1, n_accepted);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        apb_data_t rd;
        logic      err;
        int        hold_periods;
        int        target;

        seed       = 32'h2b38;
        err_value  = 0;
        err_other  = 0;
        dut_enable = 1'b0;
        decim_n    = 0;
        clk_i      = 1'b0;
        arst_n     = 1'b0;
        adc_data   = '0;
        out_ack    = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        repeat (5) @(posedge clk_i);
        arst_n <= 1'b1;
        @(posedge clk_i);
        check_flag("clk_o", clk_o, 1'b0);
        check_flag("adc_oe", adc_oe, 1'b0);
        check_flag("pslverr", pslverr, 1'b0);

        // Register map out of reset, readback, error response
        read_expect(`REG_CTRL_ADDR, "CTRL", '0);
        read_expect(`REG_DECIM_ADDR, "DECIM", '0);
        read_expect(`REG_STATUS_ADDR, "STATUS", '0);
        read_expect(`REG_LAST_ADDR, "LAST", '0);
        reg_write(`REG_CTRL_ADDR, 32'h2);
        reg_write(`REG_DECIM_ADDR, 32'h5);
        read_expect(`REG_CTRL_ADDR, "CTRL", 32'h2);
        read_expect(`REG_DECIM_ADDR, "DECIM", 32'h5);
        reg_read(4'h2, rd, err);                        // Unaligned
        check_flag("pslverr", err, 1'b1);
        check_flag("adc_oe", adc_oe, 1'b1);

        // Filtering, then decimation by 4 and by 7
        run_session(0, 20);
        run_session(3, 12);
        run_session(6, 12);

        // Back-pressure with N=0
        reg_write(`REG_DECIM_ADDR, '0);
        decim_n = 0;
        target  = n_accepted + 4;
        reg_write(`REG_CTRL_ADDR, 32'h3);
        wait_outputs(target);
        do begin
            @(posedge clk_i);
        end while (!out_rdy);
        out_ack <= 1'b0;
        hold_periods = 3 + ($random(seed) & 7);
        repeat (2 * hold_periods) @(posedge clk_i);
        out_ack <= 1'b1;
        target = n_accepted + 4;
        wait_outputs(target);
        if (ovr_model == 0) begin
            err_other++;
            $display("back-pressure at %0t caused no overrun at all", $time);
        end
        reg_read(`REG_STATUS_ADDR, rd, err);
        check_count("STATUS", ovr_count_t'(rd), ovr_count_t'(ovr_model));

        // Clear, disable, restart
        reg_write(`REG_STATUS_ADDR, 32'hFFFF_FFFF);
        reg_read(`REG_STATUS_ADDR, rd, err);
        check_count("STATUS", ovr_count_t'(rd), '0);
        reg_write(`REG_CTRL_ADDR, 32'h2);
        repeat (4) @(posedge clk_i);                    // Last result drains
        repeat (20) begin
            @(posedge clk_i);
            check_flag("clk_o", clk_o, 1'b0);
            check_flag("out_rdy", out_rdy, 1'b0);
        end
        read_expect(`REG_LAST_ADDR, "LAST", apb_data_t'(last_sampled));
        target = n_accepted + 1;
        reg_write(`REG_CTRL_ADDR, 32'h3);
        wait_outputs(target);
        check_sample("out_data", last_accepted, first_kept >> `MA_LOG2_LEN);

        $display("errors: %0d wrong values, %0d other, %0d outputs checked",
                 err_value, err_other, n_accepted);
        if (err_value + err_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hdl
hdl/adc_pkg.sv
hdl/adc_interface.sv
hdl/moving_average.sv
hdl/adc_regs.sv
hdl/adc_top.sv
bench/adc_tb.sv

// ==== hdl/adc_interface.sv ====
// External ADC clock generation, sampling and decimation
`default_nettype none

module adc_interface
    import adc_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        arst_n,
    // External ADC pins
    input  wire adc_sample_t adc_data,
    output logic             adc_oe,
    output logic             clk_o,
    // Control from the register block
    input  wire logic        enable,
    input  wire logic        oe,
    input  wire decim_t      decimation_factor,
    // Decimated stream to the filter
    output adc_sample_t      smp_data,
    output logic             smp_valid,
    // Every sample, for the LAST register
    output adc_sample_t      raw_data,
    output logic             raw_valid
);

    adc_phase_t phase;          // Current ADC clock level
    decim_t     decim_cnt;      // Samples still to skip
    logic       smp_edge;       // clk_o falls at this edge
    logic       keep;           // Sample at this edge passes decimation

    assign clk_o    = (phase == ph_high);
    assign smp_edge = enable && (phase == ph_high);
    assign keep     = smp_edge && (decim_cnt == '0);

    // Kept samples are the raw word itself
    assign smp_data = raw_data;

    // Toggle every clk_i edge, so the ADC period is two cycles
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            phase <= ph_low;
        end else if (!enable) begin
            phase <= ph_low;                    // Park clk_o low
        end else begin
            phase <= (phase == ph_low) ? ph_high : ph_low;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            adc_oe <= 1'b0;
        end else begin
            adc_oe <= oe;                       // Straight from CTRL bit 1
        end
    end

    // ADC holds its word through the high half, capture at the fall
    always_ff @(posedge clk_i) begin
        if (smp_edge) begin
            raw_data <= adc_data;
        end
    end

    // Valid pulses, one cycle after the sampling edge
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            raw_valid <= 1'b0;
            smp_valid <= 1'b0;
        end else begin
            raw_valid <= smp_edge;
            smp_valid <= keep;
        end
    end

    // Decimation down-counter
    // Held at zero while disabled, so the first sample after enable is kept
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            decim_cnt <= '0;
        end else if (!enable) begin
            decim_cnt <= '0;
        end else if (smp_edge) begin
            if (keep) begin
                decim_cnt <= decimation_factor;         // Reload, skip N next
            end else begin
                decim_cnt <= decim_cnt - decim_t'(1);
            end
        end
    end

    // A kept sample is always also a raw sample
    a_smp_is_raw: assert property (@(posedge clk_i) disable iff (!arst_n)
        smp_valid |-> raw_valid)
        else $error("smp_valid without raw_valid");

    // Disabled clock parks low from the next cycle on
    a_clk_parked: assert property (@(posedge clk_i) disable iff (!arst_n)
        !enable |=> !clk_o)
        else $error("clk_o toggling while disabled");

endmodule

`default_nettype wire

// ==== hdl/adc_pkg.sv ====
// Vector typedefs and state enums shared by the ADC front end
`default_nettype none

`include "adc_settings.svh"

package adc_pkg;

    // Data path
    typedef logic [`ADC_DATA_WIDTH-1:0]  adc_sample_t;   // One ADC word
    typedef logic [`MA_BITS_ACUM-1:0]    ma_acc_t;       // Running sum
    typedef logic [`ADC_DF_WIDTH-1:0]    decim_t;        // Keep one in N+1

    // Register bus
    typedef logic [`APB_ADDR_WIDTH-1:0]  apb_addr_t;
    typedef logic [`APB_DATA_WIDTH-1:0]  apb_data_t;
    typedef logic [`OVR_COUNT_WIDTH-1:0] ovr_count_t;    // Saturating overrun count

    // Filter output handshake
    typedef enum logic {
        ma_idle,        // Nothing offered
        ma_hold         // Result held under out_rdy
    } ma_state_t;

    // External ADC clock phase
    typedef enum logic {
        ph_low,
        ph_high
    } adc_phase_t;

endpackage

`default_nettype wire

// ==== hdl/adc_regs.sv ====
// APB slave with CTRL, DECIM, STATUS and LAST registers
`default_nettype none

`include "adc_settings.svh"

module adc_regs
    import adc_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        arst_n,
    // APB, no wait states
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire apb_addr_t   paddr,
    input  wire apb_data_t   pwdata,
    output apb_data_t        prdata,
    output logic             pready,
    output logic             pslverr,
    // Control to the data path
    output logic             enable,
    output logic             oe,
    output decim_t           decimation_factor,
    // Status from the data path
    input  wire adc_sample_t raw_data,
    input  wire logic        raw_valid,
    input  wire logic        overrun
);

    logic        acc_phase;     // Access phase of a transfer
    logic        wr_en;
    logic        addr_hit;      // Address maps to a register
    ovr_count_t  ovr_count;
    adc_sample_t last_sample;
    apb_data_t   rd_data;

    assign acc_phase = psel && penable;
    assign wr_en     = acc_phase && pwrite;
    assign pready    = 1'b1;
    assign pslverr   = acc_phase && !addr_hit;
    assign prdata    = (acc_phase && !pwrite) ? rd_data : '0;

    // Read mux and decode
    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (paddr)
            `REG_CTRL_ADDR:   rd_data = apb_data_t'({oe, enable});
            `REG_DECIM_ADDR:  rd_data = apb_data_t'(decimation_factor);
            `REG_STATUS_ADDR: rd_data = apb_data_t'(ovr_count);
            `REG_LAST_ADDR:   rd_data = apb_data_t'(last_sample);
            default:          addr_hit = 1'b0;      // Unaligned, error response
        endcase
    end

    // CTRL and DECIM, written at the end of the access phase
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            enable            <= 1'b0;
            oe                <= 1'b0;
            decimation_factor <= '0;
        end else if (wr_en) begin
            case (paddr)
                `REG_CTRL_ADDR: begin
                    enable <= pwdata[0];
                    oe     <= pwdata[1];
                end
                `REG_DECIM_ADDR: decimation_factor <= decim_t'(pwdata);
                default: ;                          // LAST is read only
            endcase
        end
    end

    // Overrun count, saturating; a write of any value clears
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            ovr_count <= '0;
        end else if (wr_en && (paddr == `REG_STATUS_ADDR)) begin
            ovr_count <= '0;
        end else if (overrun && (ovr_count != '1)) begin
            ovr_count <= ovr_count + ovr_count_t'(1);
        end
    end

    // Latest raw sample, decimated or not
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            last_sample <= '0;
        end else if (raw_valid) begin
            last_sample <= raw_data;
        end
    end

    // Access phase must follow a setup phase
    a_apb_setup: assert property (@(posedge clk_i) disable iff (!arst_n)
        penable |-> $past(psel))
        else $error("penable without preceding psel");

endmodule

`default_nettype wire

// ==== hdl/adc_settings.svh ====
// Width, window length and register address macros for the ADC front end
`ifndef ADC_SETTINGS_SVH
`define ADC_SETTINGS_SVH

// ADC word and decimation register
`define ADC_DATA_WIDTH   8
`define ADC_DF_WIDTH     32

// Moving average window
`define MA_LOG2_LEN      4
`define MA_LEN           (1 << `MA_LOG2_LEN)
`define MA_BITS_ACUM     12      // ADC_DATA_WIDTH + MA_LOG2_LEN

// APB bus
`define APB_ADDR_WIDTH   4
`define APB_DATA_WIDTH   32

// Overrun counter
`define OVR_COUNT_WIDTH  16

// Register map, byte addresses
`define REG_CTRL_ADDR    4'h0
`define REG_DECIM_ADDR   4'h4
`define REG_STATUS_ADDR  4'h8
`define REG_LAST_ADDR    4'hC

`endif

// ==== hdl/adc_top.sv ====
// Top level joining ADC interface, moving average filter and APB registers
`default_nettype none

module adc_top
    import adc_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        arst_n,
    // External ADC
    input  wire adc_sample_t adc_data,
    output wire              adc_oe,
    output wire              clk_o,
    // Filtered stream
    output wire adc_sample_t out_data,
    output wire              out_rdy,
    input  wire logic        out_ack,
    // APB
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire apb_addr_t   paddr,
    input  wire apb_data_t   pwdata,
    output wire apb_data_t   prdata,
    output wire              pready,
    output wire              pslverr
);

    logic        enable;
    logic        oe;
    decim_t      decimation_factor;
    adc_sample_t smp_data;          // Decimated stream
    logic        smp_valid;
    adc_sample_t raw_data;          // Every sample, to LAST
    logic        raw_valid;
    logic        overrun;

    adc_interface u_adc_interface (
        .clk_i             (clk_i),
        .arst_n            (arst_n),
        .adc_data          (adc_data),
        .adc_oe            (adc_oe),
        .clk_o             (clk_o),
        .enable            (enable),
        .oe                (oe),
        .decimation_factor (decimation_factor),
        .smp_data          (smp_data),
        .smp_valid         (smp_valid),
        .raw_data          (raw_data),
        .raw_valid         (raw_valid)
    );

    moving_average u_moving_average (
        .clk_i     (clk_i),
        .arst_n    (arst_n),
        .enable    (enable),
        .smp_data  (smp_data),
        .smp_valid (smp_valid),
        .out_data  (out_data),
        .out_rdy   (out_rdy),
        .out_ack   (out_ack),
        .overrun   (overrun)
    );

    adc_regs u_adc_regs (
        .clk_i             (clk_i),
        .arst_n            (arst_n),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .paddr             (paddr),
        .pwdata            (pwdata),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .enable            (enable),
        .oe                (oe),
        .decimation_factor (decimation_factor),
        .raw_data          (raw_data),
        .raw_valid         (raw_valid),
        .overrun           (overrun)
    );

endmodule

`default_nettype wire

// ==== hdl/moving_average.sv ====
// 16-sample running-sum filter with held rdy/ack output and overrun pulse
`default_nettype none

`include "adc_settings.svh"

module moving_average
    import adc_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        arst_n,
    input  wire logic        enable,
    // Decimated stream, no back-pressure
    input  wire adc_sample_t smp_data,
    input  wire logic        smp_valid,
    // Result stream
    output adc_sample_t      out_data,
    output logic             out_rdy,
    input  wire logic        out_ack,
    // Result dropped while output held
    output logic             overrun
);

    ma_state_t   state;
    adc_sample_t hist [`MA_LEN];    // hist[0] is the newest sample
    ma_acc_t     sum;               // Sum of the whole window
    ma_acc_t     sum_next;
    logic        take;              // Sample enters the window
    logic        load;              // Result goes to the output register

    assign take     = smp_valid && enable;
    assign load     = take && (!out_rdy || out_ack);
    assign out_rdy  = (state == ma_hold);

    // Add newest, drop oldest; the sum always covers the oldest, no underflow
    assign sum_next = sum + ma_acc_t'(smp_data) - ma_acc_t'(hist[`MA_LEN-1]);

    // Window and sum, zero entries stand in before the window fills
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `MA_LEN; i++) begin
                hist[i] <= '0;
            end
            sum <= '0;
        end else if (!enable) begin
            for (int i = 0; i < `MA_LEN; i++) begin
                hist[i] <= '0;                  // Restart from an empty window
            end
            sum <= '0;
        end else if (take) begin
            hist[0] <= smp_data;
            for (int i = 1; i < `MA_LEN; i++) begin
                hist[i] <= hist[i-1];
            end
            sum <= sum_next;
        end
    end

    // Divide by the window length, truncating
    always_ff @(posedge clk_i) begin
        if (load) begin
            out_data <= sum_next[`MA_BITS_ACUM-1:`MA_LOG2_LEN];
        end
    end

    // Output handshake
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ma_idle;
            overrun <= 1'b0;
        end else begin
            overrun <= 1'b0;
            case (state)
                ma_idle: begin
                    if (take) begin
                        state <= ma_hold;
                    end
                end
                ma_hold: begin
                    if (out_ack) begin
                        if (!take) begin
                            state <= ma_idle;   // Falls the cycle after ack
                        end
                    end else if (take) begin
                        overrun <= 1'b1;        // Held result wins, new one lost
                    end
                end
                default: state <= ma_idle;
            endcase
        end
    end

    // Held result does not move until acknowledged
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n)
        out_rdy && !out_ack |=> $stable(out_data))
        else $error("out_data changed while held");

    a_ovr_held: assert property (@(posedge clk_i) disable iff (!arst_n)
        overrun |-> out_rdy)
        else $error("overrun without held output");

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the ADC front end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f filelist.f \
    --top-module adc_tb \
    -o adc_sim

# The simulation may stop early on an assertion, the search below decides
sim_output=$(./obj_dir/adc_sim 2>&1) || true
echo "$sim_output"

if echo "$sim_output" | grep -q "^TEST OK$"; then
    exit 0
else
    exit 1
fi
